// ==== cpl_pkg.sv ====
`default_nettype none

package cpl_pkg;

  // pending-read entry layout
  localparam int unsigned PND_RD_W    = 53;
  localparam int unsigned TAG_LSB     = 0;
  localparam int unsigned TAG_W       = 8;
  // address bits 6:2 of the read
  localparam int unsigned ADDR_DW_LSB = 8;
  localparam int unsigned ADDR_DW_W   = 5;
  localparam int unsigned REQ_ID_LSB  = 13;
  localparam int unsigned REQ_ID_W    = 16;
  localparam int unsigned DW_LEN_LSB  = 29;
  localparam int unsigned DW_LEN_W    = 11;
  localparam int unsigned FBE_LSB     = 40;
  localparam int unsigned LBE_LSB     = 44;
  localparam int unsigned BE_W        = 4;
  localparam int unsigned ATTR_LSB    = 48;
  localparam int unsigned ATTR_W      = 2;
  localparam int unsigned TC_LSB      = 50;
  localparam int unsigned TC_W        = 3;

  // byte counts and credit arithmetic
  localparam int unsigned BCNT_W         = 13;
  localparam int unsigned CRED_W         = 11;
  localparam int unsigned RCB_BYTES      = 128;
  localparam int unsigned MPS_SMALL      = 128;
  localparam int unsigned MPS_LARGE      = 256;
  localparam int unsigned BEAT_BYTES     = 16;
  localparam int unsigned CRED_WINDOW    = 1024;
  localparam int unsigned CMD_FIFO_LIMIT = 8;
  localparam int unsigned CPLBUF_AW      = 9;

  // completion sequencer, one-hot
  typedef enum logic [13:0] {
    IDLE       = 14'b00_0000_0000_0001,
    RD_FIFO    = 14'b00_0000_0000_0010,
    LD_BCNT    = 14'b00_0000_0000_0100,
    WAIT_DATA  = 14'b00_0000_0000_1000,
    WAIT_FIRST = 14'b00_0000_0001_0000,
    WAIT_MAX   = 14'b00_0000_0010_0000,
    WAIT_LAST  = 14'b00_0000_0100_0000,
    PIPE_FIRST = 14'b00_0000_1000_0000,
    PIPE_MAX   = 14'b00_0001_0000_0000,
    PIPE_LAST  = 14'b00_0010_0000_0000,
    SEND_FIRST = 14'b00_0100_0000_0000,
    SEND_MAX   = 14'b00_1000_0000_0000,
    SEND_LAST  = 14'b01_0000_0000_0000,
    DONE       = 14'b10_0000_0000_0000
  } split_state_e;

endpackage

`default_nettype wire

// ==== cpl_split_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpl_split_ctrl (
  input  wire                        AvlClk_i,
  input  wire                        Rstn_i,
  input  wire                        pnd_empty_i,
  input  wire [10:0]                 dw_len_i,
  input  wire [4:0]                  addr_dw_i,
  input  wire [2:0]                  dev_csr_mps_i,
  input  wire [3:0]                  cmd_fifo_used_i,
  input  wire                        cmd_fifo_busy_i,
  input  wire                        credit_ok_i,
  output logic                       pnd_rd_req_o,
  output logic                       entry_load_o,
  output logic                       chunk_load_o,
  output logic [cpl_pkg::BCNT_W-1:0] chunk_bytes_o,
  output logic                       chunk_send_o,
  output logic                       first_cpl_o,
  output logic [cpl_pkg::BCNT_W-1:0] curr_bcnt_o,
  output logic                       cpl_wr_o,
  output logic                       idle_o
);

  import cpl_pkg::*;

  split_state_e      state_q;
  split_state_e      state_d;
  logic [BCNT_W-1:0] curr_bcnt_q;
  logic [BCNT_W-1:0] rcb_left_q;
  logic [BCNT_W-1:0] rcb_left_d;
  logic [BCNT_W-1:0] chunk_q;
  logic [BCNT_W-1:0] chunk_d;
  logic [BCNT_W-1:0] max_payload;
  logic              first_q;
  logic              cmd_fifo_ok;
  logic              issue_ok;
  logic              sending;
  logic              loading;

  // max payload from device control bits 7:5
  assign max_payload = (dev_csr_mps_i == 3'b000) ? BCNT_W'(MPS_SMALL) : BCNT_W'(MPS_LARGE);

  // bytes from the start address up to the next read completion boundary
  assign rcb_left_d = BCNT_W'(RCB_BYTES) - {{(BCNT_W-7){1'b0}}, addr_dw_i, 2'b00};

  // the command FIFO is checked in PIPE, one cycle ahead of cpl_wr_o
  assign cmd_fifo_ok = (cmd_fifo_used_i < 4'(CMD_FIFO_LIMIT)) & ~cmd_fifo_busy_i;
  assign issue_ok    = cmd_fifo_ok & credit_ok_i;

  always_comb
  begin
    state_d = state_q;
    chunk_d = chunk_q;
    case (state_q)
      IDLE:
      begin
        if (!pnd_empty_i)
          state_d = RD_FIFO;
      end
      RD_FIFO:
        state_d = LD_BCNT;
      LD_BCNT:
        state_d = WAIT_DATA;
      WAIT_DATA:
      begin
        // pick the kind and size of the next completion
        if (first_q && (curr_bcnt_q > rcb_left_q))
        begin
          state_d = WAIT_FIRST;
          chunk_d = rcb_left_q;
        end
        else if (!first_q && (curr_bcnt_q > max_payload))
        begin
          state_d = WAIT_MAX;
          chunk_d = max_payload;
        end
        else
        begin
          state_d = WAIT_LAST;
          chunk_d = curr_bcnt_q;
        end
      end
      WAIT_FIRST:
        state_d = PIPE_FIRST;
      WAIT_MAX:
        state_d = PIPE_MAX;
      WAIT_LAST:
        state_d = PIPE_LAST;
      PIPE_FIRST:
      begin
        if (issue_ok)
          state_d = SEND_FIRST;
      end
      PIPE_MAX:
      begin
        if (issue_ok)
          state_d = SEND_MAX;
      end
      PIPE_LAST:
      begin
        if (issue_ok)
          state_d = SEND_LAST;
      end
      // a max chunk is only taken when more bytes follow it
      SEND_FIRST,
      SEND_MAX:
        state_d = WAIT_DATA;
      SEND_LAST:
        state_d = DONE;
      DONE:
        state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  assign sending = (state_q == SEND_FIRST) | (state_q == SEND_MAX) | (state_q == SEND_LAST);
  assign loading = (state_q == WAIT_FIRST) | (state_q == WAIT_MAX) | (state_q == WAIT_LAST);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      curr_bcnt_q <= '0;
      rcb_left_q  <= '0;
      chunk_q     <= '0;
      first_q     <= 1'b0;
    end
    else
    begin
      chunk_q <= chunk_d;
      if (state_q == LD_BCNT)
      begin
        curr_bcnt_q <= {dw_len_i, 2'b00};
        rcb_left_q  <= rcb_left_d;
        first_q     <= 1'b1;
      end
      else if (sending)
      begin
        // whatever is sent comes off the outstanding count
        curr_bcnt_q <= curr_bcnt_q - chunk_q;
        first_q     <= 1'b0;
      end
    end
  end

  assign pnd_rd_req_o  = (state_q == RD_FIFO);
  assign entry_load_o  = (state_q == LD_BCNT);
  assign chunk_load_o  = loading;
  assign chunk_bytes_o = chunk_q;
  assign chunk_send_o  = sending;
  assign cpl_wr_o      = sending;
  // high one cycle early so the byte count register sees it
  assign first_cpl_o   = (state_q == LD_BCNT) | first_q;
  assign curr_bcnt_o   = curr_bcnt_q;
  assign idle_o        = (state_q == IDLE) & pnd_empty_i;

endmodule

`default_nettype wire

// ==== cpl_credit_track.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpl_credit_track (
  input  wire                          AvlClk_i,
  input  wire                          Rstn_i,
  input  wire                          rd_data_valid_i,
  input  wire                          chunk_load_i,
  input  wire [cpl_pkg::BCNT_W-1:0]    chunk_bytes_i,
  input  wire                          chunk_send_i,
  output logic                         credit_ok_o,
  output logic [cpl_pkg::CPLBUF_AW-1:0] cplbuf_wr_addr_o
);

  import cpl_pkg::*;

  logic [CRED_W-1:0]    limit_q;
  logic [CRED_W-1:0]    consumed_q;
  logic [CRED_W-1:0]    required_q;
  logic [CRED_W-1:0]    chunk_q;
  logic [CRED_W-1:0]    avail;
  logic                 credit_ok_q;
  logic [CPLBUF_AW-1:0] wr_addr_q;

  // all three counters wrap at 2048, only differences matter
  assign avail = limit_q - required_q;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      limit_q   <= '0;
      wr_addr_q <= '0;
    end
    else if (rd_data_valid_i)
    begin
      limit_q   <= limit_q + CRED_W'(BEAT_BYTES);
      wr_addr_q <= wr_addr_q + 1'b1;
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      consumed_q  <= '0;
      required_q  <= '0;
      chunk_q     <= '0;
      credit_ok_q <= 1'b0;
    end
    else
    begin
      if (chunk_load_i)
      begin
        chunk_q    <= chunk_bytes_i[CRED_W-1:0];
        required_q <= consumed_q + chunk_bytes_i[CRED_W-1:0];
      end
      if (chunk_send_i)
        consumed_q <= consumed_q + chunk_q;
      // stale until required_q holds the new chunk
      if (chunk_load_i)
        credit_ok_q <= 1'b0;
      else
        credit_ok_q <= (avail <= CRED_W'(CRED_WINDOW));
    end
  end

  assign credit_ok_o      = credit_ok_q;
  assign cplbuf_wr_addr_o = wr_addr_q;

endmodule

`default_nettype wire

// ==== cpl_hdr_build.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpl_hdr_build (
  input  wire                          AvlClk_i,
  input  wire                          Rstn_i,
  input  wire [cpl_pkg::PND_RD_W-1:0]  pnd_entry_i,
  input  wire                          entry_load_i,
  input  wire                          first_cpl_i,
  input  wire [cpl_pkg::BCNT_W-1:0]    chunk_bytes_i,
  input  wire                          chunk_send_i,
  input  wire [cpl_pkg::BCNT_W-1:0]    curr_bcnt_i,
  output logic [cpl_pkg::TAG_W-1:0]    cpl_tag_o,
  output logic [cpl_pkg::REQ_ID_W-1:0] cpl_req_id_o,
  output logic [cpl_pkg::ATTR_W-1:0]   cpl_attr_o,
  output logic [cpl_pkg::TC_W-1:0]     cpl_tc_o,
  output logic [8:0]                   cpl_dw_len_o,
  output logic [11:0]                  cpl_byte_cnt_o,
  output logic [6:0]                   cpl_lower_addr_o
);

  import cpl_pkg::*;

  logic [BE_W-1:0]     fbe;
  logic [BE_W-1:0]     lbe;
  logic [TAG_W-1:0]    tag_q;
  logic [REQ_ID_W-1:0] req_id_q;
  logic [ATTR_W-1:0]   attr_q;
  logic [TC_W-1:0]     tc_q;
  logic [1:0]          fbe_skip_q;
  logic [1:0]          lbe_skip_q;
  logic [6:0]          lower_addr_q;
  logic [BCNT_W-1:0]   bcnt_d;
  logic [11:0]         bcnt_q;

  // disabled bytes below the lowest enabled one
  function automatic logic [1:0] low_skip(input logic [3:0] be);
    logic [1:0] n;
    casez (be)
      4'b???1: n = 2'd0;
      4'b??10: n = 2'd1;
      4'b?100: n = 2'd2;
      4'b1000: n = 2'd3;
      default: n = 2'd0;
    endcase
    return n;
  endfunction

  // disabled bytes above the highest enabled one
  function automatic logic [1:0] high_skip(input logic [3:0] be);
    logic [1:0] n;
    casez (be)
      4'b1???: n = 2'd0;
      4'b01??: n = 2'd1;
      4'b001?: n = 2'd2;
      4'b0001: n = 2'd3;
      default: n = 2'd0;
    endcase
    return n;
  endfunction

  assign fbe = pnd_entry_i[FBE_LSB +: BE_W];
  assign lbe = pnd_entry_i[LBE_LSB +: BE_W];

  // entry fields held for all completions of one read
  always_ff @(posedge AvlClk_i)
  begin
    if (entry_load_i)
    begin
      tag_q      <= pnd_entry_i[TAG_LSB +: TAG_W];
      req_id_q   <= pnd_entry_i[REQ_ID_LSB +: REQ_ID_W];
      attr_q     <= pnd_entry_i[ATTR_LSB +: ATTR_W];
      tc_q       <= pnd_entry_i[TC_LSB +: TC_W];
      fbe_skip_q <= low_skip(fbe);
      lbe_skip_q <= high_skip(lbe);
    end
  end

  // later completions start on an RCB, so lower address is zero
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      lower_addr_q <= '0;
    else if (entry_load_i)
      lower_addr_q <= {pnd_entry_i[ADDR_DW_LSB +: ADDR_DW_W], low_skip(fbe)};
    else if (chunk_send_i)
      lower_addr_q <= '0;
  end

  // remaining byte count, FBE only trims the first completion
  assign bcnt_d = curr_bcnt_i
                - {{(BCNT_W-2){1'b0}}, (first_cpl_i ? fbe_skip_q : 2'd0)}
                - {{(BCNT_W-2){1'b0}}, lbe_skip_q};

  // 4096 bytes wraps to 0 in the 12-bit field
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      bcnt_q <= '0;
    else
      bcnt_q <= bcnt_d[11:0];
  end

  assign cpl_tag_o        = tag_q;
  assign cpl_req_id_o     = req_id_q;
  assign cpl_attr_o       = attr_q;
  assign cpl_tc_o         = tc_q;
  assign cpl_dw_len_o     = chunk_bytes_i[10:2];
  assign cpl_byte_cnt_o   = bcnt_q;
  assign cpl_lower_addr_o = lower_addr_q;

endmodule

`default_nettype wire

// ==== tx_resp_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tx_resp_ctrl (
  input  wire                           AvlClk_i,
  input  wire                           Rstn_i,
  input  wire                           pnd_empty_i,
  input  wire [cpl_pkg::PND_RD_W-1:0]   pnd_entry_i,
  input  wire                           rd_data_valid_i,
  input  wire [3:0]                     cmd_fifo_used_i,
  input  wire                           cmd_fifo_busy_i,
  input  wire [31:0]                    dev_csr_i,
  output logic                          pnd_rd_req_o,
  output logic                          cpl_wr_o,
  output logic [cpl_pkg::TAG_W-1:0]     cpl_tag_o,
  output logic [cpl_pkg::REQ_ID_W-1:0]  cpl_req_id_o,
  output logic [cpl_pkg::ATTR_W-1:0]    cpl_attr_o,
  output logic [cpl_pkg::TC_W-1:0]      cpl_tc_o,
  output logic [8:0]                    cpl_dw_len_o,
  output logic [11:0]                   cpl_byte_cnt_o,
  output logic [6:0]                    cpl_lower_addr_o,
  output logic [cpl_pkg::CPLBUF_AW-1:0] cplbuf_wr_addr_o,
  output logic                          idle_o
);

  import cpl_pkg::*;

  logic              entry_load;
  logic              chunk_load;
  logic [BCNT_W-1:0] chunk_bytes;
  logic              chunk_send;
  logic              first_cpl;
  logic [BCNT_W-1:0] curr_bcnt;
  logic              credit_ok;

  // sequencer, max payload comes from device control bits 7:5
  cpl_split_ctrl u_split (
    .AvlClk_i        (AvlClk_i),
    .Rstn_i          (Rstn_i),
    .pnd_empty_i     (pnd_empty_i),
    .dw_len_i        (pnd_entry_i[DW_LEN_LSB +: DW_LEN_W]),
    .addr_dw_i       (pnd_entry_i[ADDR_DW_LSB +: ADDR_DW_W]),
    .dev_csr_mps_i   (dev_csr_i[7:5]),
    .cmd_fifo_used_i (cmd_fifo_used_i),
    .cmd_fifo_busy_i (cmd_fifo_busy_i),
    .credit_ok_i     (credit_ok),
    .pnd_rd_req_o    (pnd_rd_req_o),
    .entry_load_o    (entry_load),
    .chunk_load_o    (chunk_load),
    .chunk_bytes_o   (chunk_bytes),
    .chunk_send_o    (chunk_send),
    .first_cpl_o     (first_cpl),
    .curr_bcnt_o     (curr_bcnt),
    .cpl_wr_o        (cpl_wr_o),
    .idle_o          (idle_o)
  );

  cpl_credit_track u_credit (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .rd_data_valid_i  (rd_data_valid_i),
    .chunk_load_i     (chunk_load),
    .chunk_bytes_i    (chunk_bytes),
    .chunk_send_i     (chunk_send),
    .credit_ok_o      (credit_ok),
    .cplbuf_wr_addr_o (cplbuf_wr_addr_o)
  );

  cpl_hdr_build u_hdr (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .pnd_entry_i      (pnd_entry_i),
    .entry_load_i     (entry_load),
    .first_cpl_i      (first_cpl),
    .chunk_bytes_i    (chunk_bytes),
    .chunk_send_i     (chunk_send),
    .curr_bcnt_i      (curr_bcnt),
    .cpl_tag_o        (cpl_tag_o),
    .cpl_req_id_o     (cpl_req_id_o),
    .cpl_attr_o       (cpl_attr_o),
    .cpl_tc_o         (cpl_tc_o),
    .cpl_dw_len_o     (cpl_dw_len_o),
    .cpl_byte_cnt_o   (cpl_byte_cnt_o),
    .cpl_lower_addr_o (cpl_lower_addr_o)
  );

endmodule

`default_nettype wire

// ==== tx_resp_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module tx_resp_chk (
  input wire                          AvlClk_i,
  input wire                          Rstn_i,
  input wire                          pnd_empty_i,
  input wire                          pnd_rd_req_o,
  input wire                          rd_data_valid_i,
  input wire [3:0]                    cmd_fifo_used_i,
  input wire                          cmd_fifo_busy_i,
  input wire                          cpl_wr_o,
  input wire [cpl_pkg::CPLBUF_AW-1:0] cplbuf_wr_addr_o,
  input wire                          idle_o
);

  import cpl_pkg::*;

  int unsigned fail_cnt;

  initial
    fail_cnt = 0;

  // the command FIFO is sampled in PIPE, one cycle ahead of the write
  a_cmd_fifo_stall: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    (cmd_fifo_used_i >= 4'(CMD_FIFO_LIMIT) || cmd_fifo_busy_i) |=> !cpl_wr_o)
  else
  begin
    fail_cnt++;
    $error("completion written while the command FIFO was full or busy");
  end

  a_pop_not_empty: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    pnd_rd_req_o |-> !pnd_empty_i)
  else
  begin
    fail_cnt++;
    $error("pending-read FIFO popped while empty");
  end

  // one address per returned beat, wrapping with the buffer
  a_addr_step: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    rd_data_valid_i |=> cplbuf_wr_addr_o == CPLBUF_AW'($past(cplbuf_wr_addr_o) + 1'b1))
  else
  begin
    fail_cnt++;
    $error("buffer address did not step by one on a beat");
  end

  a_addr_hold: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    !rd_data_valid_i |=> $stable(cplbuf_wr_addr_o))
  else
  begin
    fail_cnt++;
    $error("buffer address moved without a beat");
  end

  a_idle_after_reset: assert property (@(posedge AvlClk_i)
    $rose(Rstn_i) |-> idle_o)
  else
  begin
    fail_cnt++;
    $error("idle not reported after reset release");
  end

endmodule

bind tx_resp_ctrl tx_resp_chk u_chk (
  .AvlClk_i         (AvlClk_i),
  .Rstn_i           (Rstn_i),
  .pnd_empty_i      (pnd_empty_i),
  .pnd_rd_req_o     (pnd_rd_req_o),
  .rd_data_valid_i  (rd_data_valid_i),
  .cmd_fifo_used_i  (cmd_fifo_used_i),
  .cmd_fifo_busy_i  (cmd_fifo_busy_i),
  .cpl_wr_o         (cpl_wr_o),
  .cplbuf_wr_addr_o (cplbuf_wr_addr_o),
  .idle_o           (idle_o)
);

`default_nettype wire

// ==== tb_tx_resp.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_tx_resp;

  import cpl_pkg::*;

  localparam int NUM_REQ     = 31;
  localparam int CYC_PER_REQ = 200;
  // keeps returned data well inside the credit window
  localparam int LEAD_MAX    = 512;

  logic                  clk;
  logic                  rstn;
  logic                  pnd_empty;
  logic [PND_RD_W-1:0]   pnd_entry;
  logic                  rd_data_valid;
  logic [3:0]            cmd_used;
  logic                  cmd_busy;
  logic [31:0]           dev_csr;
  wire                   pnd_rd_req;
  wire                   cpl_wr;
  wire [TAG_W-1:0]       cpl_tag;
  wire [REQ_ID_W-1:0]    cpl_req_id;
  wire [ATTR_W-1:0]      cpl_attr;
  wire [TC_W-1:0]        cpl_tc;
  wire [8:0]             cpl_dw_len;
  wire [11:0]            cpl_byte_cnt;
  wire [6:0]             cpl_lower_addr;
  wire [CPLBUF_AW-1:0]   cplbuf_wr_addr;
  wire                   idle;

  logic [PND_RD_W-1:0] pnd_q[$];
  // {tag, req id, attr, tc, dw len, byte count, lower address}
  logic [56:0]         exp_q[$];
  logic [PND_RD_W-1:0] popped;
  logic [PND_RD_W-1:0] rand_entries[24];
  integer              seed;
  logic [31:0]         rnd;
  logic [31:0]         r1;
  logic [31:0]         r2;
  logic [3:0]          fbe_r;
  logic [3:0]          lbe_r;
  int                  errors;
  int                  cpl_count;
  int                  sent_bytes;
  int                  beats_seen;
  int                  beats_given;
  int                  beats_needed;
  int                  test_start;
  bit                  hold_beats;

  tx_resp_ctrl DUT (
    .AvlClk_i         (clk),
    .Rstn_i           (rstn),
    .pnd_empty_i      (pnd_empty),
    .pnd_entry_i      (pnd_entry),
    .rd_data_valid_i  (rd_data_valid),
    .cmd_fifo_used_i  (cmd_used),
    .cmd_fifo_busy_i  (cmd_busy),
    .dev_csr_i        (dev_csr),
    .pnd_rd_req_o     (pnd_rd_req),
    .cpl_wr_o         (cpl_wr),
    .cpl_tag_o        (cpl_tag),
    .cpl_req_id_o     (cpl_req_id),
    .cpl_attr_o       (cpl_attr),
    .cpl_tc_o         (cpl_tc),
    .cpl_dw_len_o     (cpl_dw_len),
    .cpl_byte_cnt_o   (cpl_byte_cnt),
    .cpl_lower_addr_o (cpl_lower_addr),
    .cplbuf_wr_addr_o (cplbuf_wr_addr),
    .idle_o           (idle)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic note_fail(input string msg);
    $display("t=%0t %s", $time, msg);
    errors++;
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act)
    else
    begin
      $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  function automatic logic [PND_RD_W-1:0] make_entry(
    input logic [7:0]  tag,
    input logic [4:0]  addr_dw,
    input logic [15:0] req_id,
    input logic [10:0] dw_len,
    input logic [3:0]  fbe,
    input logic [3:0]  lbe,
    input logic [1:0]  attr,
    input logic [2:0]  tc
  );
    return {tc, attr, lbe, fbe, dw_len, req_id, addr_dw, tag};
  endfunction

  // expected completions of one read
  task automatic model_cpls(input logic [PND_RD_W-1:0] e, input int mps);
    int rem;
    int n;
    int fskip;
    int lskip;
    int addr;
    int first_left;
    int bcnt;
    int la;
    bit first;
    logic [3:0] fbe;
    logic [3:0] lbe;
    fbe = e[FBE_LSB +: BE_W];
    lbe = e[LBE_LSB +: BE_W];
    fskip = 0;
    lskip = 0;
    for (int i = 3; i >= 0; i--)
    begin
      if (fbe[i])
        fskip = i;
    end
    for (int i = 0; i < 4; i++)
    begin
      if (lbe[i])
        lskip = 3 - i;
    end
    addr = int'(e[ADDR_DW_LSB +: ADDR_DW_W]) * 4;
    rem = int'(e[DW_LEN_LSB +: DW_LEN_W]) * 4;
    first_left = 128 - addr;
    first = 1'b1;
    while (rem > 0)
    begin
      if (first && rem > first_left)
        n = first_left;
      else if (!first && rem > mps)
        n = mps;
      else
        n = rem;
      bcnt = rem - (first ? fskip : 0) - lskip;
      la = first ? addr + fskip : 0;
      exp_q.push_back({e[TAG_LSB +: TAG_W], e[REQ_ID_LSB +: REQ_ID_W], e[ATTR_LSB +: ATTR_W],
                       e[TC_LSB +: TC_W], 9'(n / 4), 12'(bcnt), 7'(la)});
      rem = rem - n;
      first = 1'b0;
    end
  endtask

  task automatic push_entry(input logic [PND_RD_W-1:0] e);
    pnd_q.push_back(e);
    pnd_empty <= 1'b0;
    beats_needed += int'(e[DW_LEN_LSB +: DW_LEN_W]) / 4;
  endtask

  task automatic take_cpl();
    logic [56:0] x;
    int n;
    int avail;
    n = int'(cpl_dw_len) * 4;
    avail = (16 * beats_seen - sent_bytes - n) & 2047;
    assert (avail <= 1024)
    else
      note_fail($sformatf("completion of %0d bytes issued ahead of the returned data", n));
    if (exp_q.size() == 0)
      note_fail("completion issued with none expected");
    else
    begin
      x = exp_q.pop_front();
      check_val("cpl_tag_o", x[56:49], cpl_tag);
      check_val("cpl_req_id_o", x[48:33], cpl_req_id);
      check_val("cpl_attr_o", x[32:31], cpl_attr);
      check_val("cpl_tc_o", x[30:28], cpl_tc);
      check_val("cpl_dw_len_o", x[27:19], cpl_dw_len);
      check_val("cpl_byte_cnt_o", x[18:7], cpl_byte_cnt);
      check_val("cpl_lower_addr_o", x[6:0], cpl_lower_addr);
    end
    sent_bytes += n;
    cpl_count++;
  endtask

  // show-ahead FIFO, the popped entry stays until the next pop
  always @(posedge clk)
  begin
    if (rstn && pnd_rd_req)
    begin
      if (pnd_q.size() == 0)
        note_fail("read request with the entry FIFO empty");
      else
      begin
        if (exp_q.size() != 0)
          note_fail("entry popped while completions of the last read were outstanding");
        popped = pnd_q.pop_front();
        pnd_entry <= popped;
        pnd_empty <= (pnd_q.size() == 0);
        model_cpls(popped, (dev_csr[7:5] == 3'b000) ? 128 : 256);
      end
    end
  end

  always @(posedge clk)
  begin
    if (rstn)
    begin
      if (cpl_wr)
        take_cpl();
      if (rd_data_valid)
        beats_seen++;
    end
  end

  // random data beats, only as many as the queued reads need
  always @(posedge clk)
  begin
    if (!rstn)
      rd_data_valid <= 1'b0;
    else if (!hold_beats && beats_given < beats_needed
             && (16 * beats_given - sent_bytes) < LEAD_MAX)
    begin
      rnd = $random(seed);
      rd_data_valid <= rnd[0];
      if (rnd[0])
        beats_given++;
    end
    else
      rd_data_valid <= 1'b0;
  end

  task automatic wait_done();
    @(posedge clk);
    while (pnd_q.size() != 0 || exp_q.size() != 0 || !idle)
      @(posedge clk);
  endtask

  task automatic expect_stall(input string what, input int cycles);
    int start;
    start = cpl_count;
    repeat (cycles) @(posedge clk);
    check_val(what, 0, cpl_count - start);
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s finished, %0d completions, %0d errors so far",
             num, name, cpl_count - test_start, errors);
    test_start = cpl_count;
  endtask

  initial
  begin
    repeat (NUM_REQ * CYC_PER_REQ) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish",
             NUM_REQ * CYC_PER_REQ);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    seed = 32'hc658_c20a;
    rstn = 1'b0;
    pnd_empty = 1'b1;
    pnd_entry = '0;
    rd_data_valid = 1'b0;
    cmd_used = 4'd0;
    cmd_busy = 1'b0;
    dev_csr = 32'h0;
    errors = 0;
    cpl_count = 0;
    sent_bytes = 0;
    beats_seen = 0;
    beats_given = 0;
    beats_needed = 0;
    test_start = 0;
    hold_beats = 1'b0;

    // random reads for the buffer wrap test
    for (int i = 0; i < 24; i++)
    begin
      r1 = $random(seed);
      r2 = $random(seed);
      fbe_r = (r2[3:0] == 4'h0) ? 4'hf : r2[3:0];
      lbe_r = (r2[7:4] == 4'h0) ? 4'hf : r2[7:4];
      rand_entries[i] = make_entry(r1[7:0], r2[12:8], r1[23:8],
                                   11'(96 + 4 * (int'(r2[20:16]) % 9)),
                                   fbe_r, lbe_r, r1[25:24], r1[28:26]);
    end

    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);

    // single completion below the RCB
    push_entry(make_entry(8'h5a, 5'd3, 16'h1234, 11'd8, 4'b1100, 4'b0011, 2'b01, 3'd5));
    wait_done();
    report_test(1, "single completion");

    // split across the RCB with 128-byte max payload
    push_entry(make_entry(8'h21, 5'd20, 16'hbeef, 11'd200, 4'b1000, 4'b0111, 2'b10, 3'd2));
    wait_done();
    report_test(2, "RCB split");

    @(posedge clk);
    dev_csr <= 32'h0000_0020;
    push_entry(make_entry(8'h22, 5'd20, 16'hbeef, 11'd200, 4'b1000, 4'b0111, 2'b10, 3'd2));
    wait_done();
    report_test(3, "256-byte max payload");

    hold_beats = 1'b1;
    push_entry(make_entry(8'h30, 5'd0, 16'h0a0b, 11'd64, 4'hf, 4'hf, 2'b00, 3'd0));
    expect_stall("cpl_wr_o pulses with data withheld", 60);
    // entry FIFO is empty here but the read is still in progress
    check_val("idle_o", 0, idle);
    hold_beats = 1'b0;
    wait_done();
    report_test(4, "data withheld");

    @(posedge clk);
    cmd_busy <= 1'b1;
    push_entry(make_entry(8'h41, 5'd7, 16'h4001, 11'd16, 4'b1110, 4'b0001, 2'b11, 3'd7));
    push_entry(make_entry(8'h42, 5'd31, 16'h4002, 11'd32, 4'b0100, 4'b1111, 2'b00, 3'd1));
    push_entry(make_entry(8'h43, 5'd0, 16'h4003, 11'd48, 4'b0011, 4'b0011, 2'b01, 3'd3));
    expect_stall("cpl_wr_o pulses with the command FIFO busy", 60);
    cmd_busy <= 1'b0;
    cmd_used <= 4'd8;
    expect_stall("cpl_wr_o pulses with the command FIFO full", 40);
    cmd_used <= 4'd3;
    wait_done();
    report_test(5, "command FIFO back-pressure");

    @(posedge clk);
    cmd_used <= 4'd0;
    dev_csr <= 32'h0000_00a0;
    for (int i = 0; i < 24; i++)
      push_entry(rand_entries[i]);
    wait_done();
    if (beats_seen <= 512)
      note_fail("too few beats to wrap the completion buffer address");
    check_val("cplbuf_wr_addr_o", beats_seen % 512, cplbuf_wr_addr);
    report_test(6, "random reads and buffer wrap");

    $display("summary: 6 tests, %0d completions, %0d testbench errors, %0d assertion failures",
             cpl_count, errors, DUT.u_chk.fail_cnt);
    if (errors == 0 && DUT.u_chk.fail_cnt == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
cpl_pkg.sv
cpl_split_ctrl.sv
cpl_credit_track.sv
cpl_hdr_build.sv
tx_resp_ctrl.sv
tx_resp_chk.sv
tb_tx_resp.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_tx_resp \
  -f flist.f -o sim_tx_resp || { echo "run.sh: build failed"; exit 1; }
./obj_dir/sim_tx_resp +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -x "Regression passed" > /dev/null \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }
